//--- logic/ddr_pkg.sv
`default_nettype none

package ddr_pkg;

	// widths
	localparam int DEV_IDX_W   = 5;	// device index from the register file
	localparam int ADDR_W      = 7;	// dynamic address
	localparam int BITCNT_W    = 6;
	localparam int STALL_W     = 5;
	localparam int REGF_ADDR_W = 12;
	localparam int SPECIAL_W   = 8;	// byte handed to the serializer in the address state

	typedef logic [REGF_ADDR_W-1:0] regf_addr_t;

	localparam logic [ADDR_W-1:0] DYN_ADDR_BASE = 7'd8;	// index 0 maps to address 8

	// scl stall lengths, in scl cycles
	localparam logic [STALL_W-1:0] RESTART_STALL = 5'd10;
	localparam logic [STALL_W-1:0] EXIT_STALL    = 5'd16;

	// bit counts inside crc_value that ask the staller to hold scl
	localparam logic [BITCNT_W-1:0] STALL_BIT_LO = 6'd11;
	localparam logic [BITCNT_W-1:0] STALL_BIT_HI = 6'd12;

	// first register-file entry per transfer kind
	localparam regf_addr_t REGF_WR_BASE  = 12'd1;
	localparam regf_addr_t REGF_IMM_BASE = 12'd20;
	localparam regf_addr_t REGF_RD_BASE  = 12'd10;

	typedef enum logic [4:0] {
		st_idle        = 5'd0,
		st_cmd_pre     = 5'd1,
		st_rw_bit      = 5'd2,
		st_seven_zeros = 5'd3,
		st_address     = 5'd4,
		st_parity      = 5'd5,	// shared by command and data words
		st_ack_pre     = 5'd6,
		st_ack_wait    = 5'd7,
		st_data_byte0  = 5'd8,
		st_data_byte1  = 5'd9,
		st_data_pre    = 5'd10,
		st_crc_pre0    = 5'd11,
		st_crc_pre1    = 5'd12,
		st_token_crc   = 5'd13,
		st_crc_value   = 5'd14,
		st_error       = 5'd15,
		st_restart     = 5'd16,
		st_exit        = 5'd17
	} ddr_state_t;

	// serializer modes, encoding fixed by the tx lane
	typedef enum logic [3:0] {
		tx_seven_zeros  = 4'd0,
		tx_ser_address  = 4'd1,
		tx_special_pre  = 4'd2,	// 01 command preamble
		tx_one_pre      = 4'd3,
		tx_zero_pre     = 4'd4,
		tx_ser_byte     = 4'd5,
		tx_calc_parity  = 4'd6,
		tx_crc_value    = 4'd7,
		tx_token_crc    = 4'd8,
		tx_restart_pat  = 4'd9,
		tx_exit_pat     = 4'd10
	} tx_mode_t;

	// deserializer modes, gaps are codes the rx lane reserves
	typedef enum logic [3:0] {
		rx_preamble     = 4'd0,
		rx_deser_byte   = 4'd3,
		rx_check_token  = 4'd4,
		rx_check_parity = 4'd5,
		rx_check_crc    = 4'd6,
		rx_error        = 4'd7
	} rx_mode_t;

	typedef enum logic [3:0] {
		err_success    = 4'd0,
		err_crc        = 4'd1,
		err_parity     = 4'd2,
		err_frame      = 4'd3,
		err_nack       = 4'd5,
		err_short_read = 4'd7
	} err_t;

endpackage

`default_nettype wire

//--- logic/ddr_phase_if.sv
`default_nettype none

interface ddr_phase_if;

	ddr_pkg::ddr_state_t state;	// current frame state
	logic dir;			// 1 = read transfer
	logic end_exit;			// frame closes with exit instead of restart
	logic phase_done;		// either lane finished its phase
	logic start;			// idle accepted a new frame this cycle
	logic data_phase;		// ack seen, parity now belongs to data words

	modport seq (
		output state,
		output dir,
		output end_exit,
		output phase_done,
		output start,
		output data_phase
	);

	modport follow (
		input state,
		input dir,
		input end_exit,
		input phase_done,
		input start,
		input data_phase
	);

endinterface

`default_nettype wire

//--- logic/ddr_frame_fsm.sv
`default_nettype none

module ddr_frame_fsm (
	input  wire           i_sys_clk,
	input  wire           i_sys_rst,
	input  wire           i_engine_en,
	input  wire           i_tx_mode_done,
	input  wire           i_rx_mode_done,
	input  wire           i_rx_pre,
	input  wire           i_rx_error,
	input  wire           i_frmcnt_last,
	input  wire           i_regf_wr_rd_bit,
	input  wire           i_regf_toc,
	input  wire           i_regf_short_read,
	output logic          o_engine_done,
	output ddr_pkg::err_t o_regf_error_type,
	ddr_phase_if.seq      phase
);

	ddr_pkg::ddr_state_t state_nxt;
	ddr_pkg::ddr_state_t close_st;	// restart or exit, fixed per frame
	ddr_pkg::err_t err_nxt;
	logic err_hit;			// a check failed this cycle
	logic rd_check;			// read data past the command, target drives sda

	assign phase.phase_done = i_tx_mode_done | i_rx_mode_done;
	assign phase.start = (phase.state == ddr_pkg::st_idle) && i_engine_en;
	assign close_st = phase.end_exit ? ddr_pkg::st_exit : ddr_pkg::st_restart;
	assign rd_check = phase.dir && phase.phase_done;

	always_comb
	begin
		state_nxt = phase.state;
		err_hit = 1'b0;
		err_nxt = ddr_pkg::err_success;
		case (phase.state)
			ddr_pkg::st_idle:
				if (i_engine_en)
					state_nxt = ddr_pkg::st_cmd_pre;
			ddr_pkg::st_cmd_pre:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_rw_bit;
			ddr_pkg::st_rw_bit:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_seven_zeros;
			ddr_pkg::st_seven_zeros:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_address;
			ddr_pkg::st_address:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_parity;
			ddr_pkg::st_parity:
				if (phase.phase_done)
				begin
					if (!phase.data_phase)
						state_nxt = ddr_pkg::st_ack_pre;	// command parity
					else if (phase.dir && i_rx_error)
					begin
						state_nxt = ddr_pkg::st_error;
						err_hit = 1'b1;
						err_nxt = ddr_pkg::err_parity;
					end
					else if (i_frmcnt_last)
						state_nxt = ddr_pkg::st_crc_pre0;
					else
						state_nxt = ddr_pkg::st_data_pre;
				end
			ddr_pkg::st_ack_pre:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_ack_wait;
			ddr_pkg::st_ack_wait:
				if (phase.phase_done)
				begin
					if (!i_rx_pre)	// target pulled sda low, ack
						state_nxt = ddr_pkg::st_data_byte0;
					else
					begin
						state_nxt = ddr_pkg::st_error;
						err_hit = 1'b1;
						err_nxt = ddr_pkg::err_nack;
					end
				end
			ddr_pkg::st_data_byte0:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_data_byte1;
			ddr_pkg::st_data_byte1:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_parity;
			ddr_pkg::st_data_pre:
				if (phase.phase_done)
				begin
					if (!phase.dir || i_rx_pre)	// another word follows
						state_nxt = ddr_pkg::st_data_byte0;
					else if (i_regf_short_read)
					begin
						state_nxt = ddr_pkg::st_error;
						err_hit = 1'b1;
						err_nxt = ddr_pkg::err_short_read;
					end
					else
						state_nxt = ddr_pkg::st_crc_pre0;	// early end is allowed
				end
			ddr_pkg::st_crc_pre0:
				if (phase.phase_done)
					state_nxt = ddr_pkg::st_crc_pre1;
			ddr_pkg::st_crc_pre1:
				if (rd_check && !i_rx_pre)
				begin
					state_nxt = ddr_pkg::st_error;
					err_hit = 1'b1;
					err_nxt = ddr_pkg::err_frame;
				end
				else if (phase.phase_done)
					state_nxt = ddr_pkg::st_token_crc;
			ddr_pkg::st_token_crc:
				if (rd_check && i_rx_error)
				begin
					state_nxt = ddr_pkg::st_error;
					err_hit = 1'b1;
					err_nxt = ddr_pkg::err_frame;	// bad token
				end
				else if (phase.phase_done)
					state_nxt = ddr_pkg::st_crc_value;
			ddr_pkg::st_crc_value:
				if (rd_check && i_rx_error)
				begin
					state_nxt = ddr_pkg::st_error;
					err_hit = 1'b1;
					err_nxt = ddr_pkg::err_crc;
				end
				else if (phase.phase_done)
					state_nxt = close_st;
			ddr_pkg::st_error:
				if (i_rx_mode_done)
					state_nxt = close_st;
			ddr_pkg::st_restart, ddr_pkg::st_exit:
				if (i_tx_mode_done)
					state_nxt = ddr_pkg::st_idle;
			default:
				state_nxt = ddr_pkg::st_idle;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			phase.state <= ddr_pkg::st_idle;
			phase.dir <= 1'b0;
			phase.end_exit <= 1'b0;
			phase.data_phase <= 1'b0;
			o_engine_done <= 1'b0;
			o_regf_error_type <= ddr_pkg::err_success;
		end
		else
		begin
			phase.state <= state_nxt;
			// pulse lands in the first idle cycle
			o_engine_done <= (state_nxt == ddr_pkg::st_idle) &&
				((phase.state == ddr_pkg::st_restart) || (phase.state == ddr_pkg::st_exit));
			if (phase.start)
			begin
				phase.dir <= i_regf_wr_rd_bit;
				phase.end_exit <= i_regf_toc;
				phase.data_phase <= 1'b0;
				o_regf_error_type <= ddr_pkg::err_success;
			end
			else
			begin
				if (state_nxt == ddr_pkg::st_data_byte0)
					phase.data_phase <= 1'b1;
				if (err_hit && (o_regf_error_type == ddr_pkg::err_success))
					o_regf_error_type <= err_nxt;	// keep the first failure
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/ddr_lane_ctrl.sv
`default_nettype none

module ddr_lane_ctrl (
	input  wire [ddr_pkg::DEV_IDX_W-1:0] i_regf_dev_index,
	input  wire [ddr_pkg::BITCNT_W-1:0]  i_bitcnt,
	input  wire                          i_tx_mode_done,
	output logic                         o_tx_en,
	output ddr_pkg::tx_mode_t            o_tx_mode,
	output logic                         o_rx_en,
	output ddr_pkg::rx_mode_t            o_rx_mode,
	output logic                         o_frmcnt_en,
	output logic                         o_bitcnt_en,
	output logic                         o_bitcnt_rst,
	output logic [ddr_pkg::SPECIAL_W-1:0] o_tx_special_data,
	output logic                         o_sclstall_en,
	output logic [ddr_pkg::STALL_W-1:0]  o_sclstall_no_of_cycles,
	ddr_phase_if.follow                  phase
);

	logic [ddr_pkg::ADDR_W-1:0] dyn_addr;
	logic [ddr_pkg::STALL_W-1:0] stall_len;
	logic crc_stall_bit;	// bit positions in the crc where scl is held
	logic cmd_phase;	// command word still on the bus

	assign dyn_addr = {{(ddr_pkg::ADDR_W - ddr_pkg::DEV_IDX_W){1'b0}}, i_regf_dev_index}
		+ ddr_pkg::DYN_ADDR_BASE;
	assign stall_len = phase.end_exit ? ddr_pkg::EXIT_STALL : ddr_pkg::RESTART_STALL;
	assign crc_stall_bit = (i_bitcnt == ddr_pkg::STALL_BIT_LO) ||
		(i_bitcnt == ddr_pkg::STALL_BIT_HI);
	assign cmd_phase = !phase.data_phase && (phase.state inside {ddr_pkg::st_cmd_pre,
		ddr_pkg::st_rw_bit, ddr_pkg::st_seven_zeros, ddr_pkg::st_address, ddr_pkg::st_parity,
		ddr_pkg::st_ack_pre, ddr_pkg::st_ack_wait});

	// counters run for the whole frame, the word counter not during the command
	assign o_bitcnt_en = (phase.state != ddr_pkg::st_idle);
	assign o_frmcnt_en = (phase.state != ddr_pkg::st_idle) && !cmd_phase;
	assign o_bitcnt_rst = (phase.state == ddr_pkg::st_error);

	always_comb
	begin
		o_tx_en = 1'b0;
		o_tx_mode = ddr_pkg::tx_seven_zeros;
		o_rx_en = 1'b0;
		o_rx_mode = ddr_pkg::rx_preamble;
		o_tx_special_data = '0;
		o_sclstall_en = 1'b0;
		o_sclstall_no_of_cycles = '0;
		case (phase.state)
			ddr_pkg::st_cmd_pre:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = ddr_pkg::tx_special_pre;
			end
			ddr_pkg::st_rw_bit:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = phase.dir ? ddr_pkg::tx_one_pre : ddr_pkg::tx_zero_pre;
			end
			ddr_pkg::st_seven_zeros:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = ddr_pkg::tx_seven_zeros;
			end
			ddr_pkg::st_address:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = ddr_pkg::tx_ser_address;
				o_tx_special_data = {{(ddr_pkg::SPECIAL_W - ddr_pkg::ADDR_W){1'b0}}, dyn_addr};
			end
			ddr_pkg::st_parity:
				if (phase.dir && phase.data_phase)	// target sends the read parity
				begin
					o_rx_en = 1'b1;
					o_rx_mode = ddr_pkg::rx_check_parity;
				end
				else
				begin
					o_tx_en = 1'b1;
					o_tx_mode = ddr_pkg::tx_calc_parity;
				end
			ddr_pkg::st_ack_pre, ddr_pkg::st_crc_pre0:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = (phase.state == ddr_pkg::st_ack_pre) ?
					ddr_pkg::tx_one_pre : ddr_pkg::tx_zero_pre;
			end
			ddr_pkg::st_ack_wait:
				o_rx_en = 1'b1;	// listen for the ack bit straight away
			ddr_pkg::st_data_byte0, ddr_pkg::st_data_byte1:
			begin
				o_tx_en = !phase.dir;
				o_tx_mode = ddr_pkg::tx_ser_byte;
				o_rx_en = phase.dir;
				o_rx_mode = ddr_pkg::rx_deser_byte;
			end
			ddr_pkg::st_data_pre, ddr_pkg::st_crc_pre1:
			begin
				o_tx_en = !phase.dir;
				o_tx_mode = ddr_pkg::tx_one_pre;
				o_rx_en = phase.dir;	// target decides continue or end
			end
			ddr_pkg::st_token_crc:
			begin
				o_tx_en = !phase.dir;
				o_tx_mode = ddr_pkg::tx_token_crc;
				o_rx_en = phase.dir;
				o_rx_mode = ddr_pkg::rx_check_token;
			end
			ddr_pkg::st_crc_value:
			begin
				o_tx_en = !phase.dir;
				o_tx_mode = ddr_pkg::tx_crc_value;
				o_rx_en = phase.dir;
				o_rx_mode = ddr_pkg::rx_check_crc;
				o_sclstall_en = crc_stall_bit;
				o_sclstall_no_of_cycles = stall_len;
			end
			ddr_pkg::st_error:
			begin
				o_rx_en = 1'b1;
				o_rx_mode = ddr_pkg::rx_error;
			end
			ddr_pkg::st_restart, ddr_pkg::st_exit:
			begin
				o_tx_en = 1'b1;
				o_tx_mode = phase.end_exit ? ddr_pkg::tx_exit_pat : ddr_pkg::tx_restart_pat;
				o_sclstall_en = !i_tx_mode_done;	// release with the pattern
				o_sclstall_no_of_cycles = stall_len;
			end
			default:
				o_tx_en = 1'b0;	// idle keeps both lanes quiet
		endcase
	end

endmodule

`default_nettype wire

//--- logic/ddr_regf_addr.sv
`default_nettype none

module ddr_regf_addr (
	input  wire                 i_sys_clk,
	input  wire                 i_sys_rst,
	input  wire [2:0]           i_regf_cmd_attr,	// bit 0 marks an immediate write
	input  wire                 i_tx_mode_done,
	input  wire                 i_rx_mode_done,
	output ddr_pkg::regf_addr_t o_regf_addr,
	output logic                o_regf_rd_en,
	output logic                o_regf_wr_en,
	ddr_phase_if.follow         phase
);

	ddr_pkg::regf_addr_t base_addr;
	logic data_byte;	// one of the two byte states of a word
	logic byte_done;

	assign data_byte = (phase.state == ddr_pkg::st_data_byte0) ||
		(phase.state == ddr_pkg::st_data_byte1);

	// write data is fetched from the regfile, read data is stored into it
	assign o_regf_rd_en = data_byte && !phase.dir;
	assign o_regf_wr_en = data_byte && phase.dir;
	assign byte_done = (o_regf_rd_en && i_tx_mode_done) || (o_regf_wr_en && i_rx_mode_done);

	always_comb
	begin
		if (phase.dir)
			base_addr = ddr_pkg::REGF_RD_BASE;
		else if (i_regf_cmd_attr[0])
			base_addr = ddr_pkg::REGF_IMM_BASE;
		else
			base_addr = ddr_pkg::REGF_WR_BASE;
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_regf_addr <= '0;
		else if (phase.start)
			o_regf_addr <= '0;
		else if ((phase.state == ddr_pkg::st_ack_wait) && phase.phase_done)
			o_regf_addr <= base_addr;	// a nack parks here, no byte follows
		else if (byte_done)
			o_regf_addr <= o_regf_addr + ddr_pkg::regf_addr_t'(1);
	end

endmodule

`default_nettype wire

//--- logic/ddr_engine.sv
`default_nettype none

module ddr_engine (
	input  wire                           i_sys_clk,
	input  wire                           i_sys_rst,
	input  wire                           i_engine_en,
	input  wire                           i_frmcnt_last,
	input  wire                           i_tx_mode_done,
	input  wire                           i_rx_mode_done,
	input  wire                           i_rx_pre,
	input  wire                           i_rx_error,
	input  wire                           i_regf_toc,	// 1 = exit, 0 = restart
	input  wire [ddr_pkg::DEV_IDX_W-1:0]  i_regf_dev_index,
	input  wire                           i_regf_short_read,
	input  wire                           i_regf_wr_rd_bit,	// 1 = read
	input  wire [2:0]                     i_regf_cmd_attr,
	input  wire [ddr_pkg::BITCNT_W-1:0]   i_bitcnt,
	output logic                          o_tx_en,
	output ddr_pkg::tx_mode_t             o_tx_mode,
	output logic                          o_rx_en,
	output ddr_pkg::rx_mode_t             o_rx_mode,
	output logic                          o_frmcnt_en,
	output logic                          o_bitcnt_en,
	output logic                          o_bitcnt_rst,
	output logic                          o_regf_wr_en,
	output logic                          o_regf_rd_en,
	output ddr_pkg::regf_addr_t           o_regf_addr,
	output logic                          o_sclstall_en,
	output logic [ddr_pkg::STALL_W-1:0]   o_sclstall_no_of_cycles,
	output logic                          o_engine_done,
	output logic [ddr_pkg::SPECIAL_W-1:0] o_tx_special_data,
	output ddr_pkg::err_t                 o_regf_error_type
);

	ddr_phase_if phase_bus ();	// state and latched attributes of the frame

	ddr_frame_fsm frame_fsm_i (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_tx_mode_done    (i_tx_mode_done),
		.i_rx_mode_done    (i_rx_mode_done),
		.i_rx_pre          (i_rx_pre),
		.i_rx_error        (i_rx_error),
		.i_frmcnt_last     (i_frmcnt_last),
		.i_regf_wr_rd_bit  (i_regf_wr_rd_bit),
		.i_regf_toc        (i_regf_toc),
		.i_regf_short_read (i_regf_short_read),
		.o_engine_done     (o_engine_done),
		.o_regf_error_type (o_regf_error_type),
		.phase             (phase_bus.seq)
	);

	ddr_lane_ctrl lane_ctrl_i (
		.i_regf_dev_index        (i_regf_dev_index),
		.i_bitcnt                (i_bitcnt),
		.i_tx_mode_done          (i_tx_mode_done),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_frmcnt_en             (o_frmcnt_en),
		.o_bitcnt_en             (o_bitcnt_en),
		.o_bitcnt_rst            (o_bitcnt_rst),
		.o_tx_special_data       (o_tx_special_data),
		.o_sclstall_en           (o_sclstall_en),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
		.phase                   (phase_bus.follow)
	);

	ddr_regf_addr regf_addr_i (
		.i_sys_clk       (i_sys_clk),
		.i_sys_rst       (i_sys_rst),
		.i_regf_cmd_attr (i_regf_cmd_attr),
		.i_tx_mode_done  (i_tx_mode_done),
		.i_rx_mode_done  (i_rx_mode_done),
		.o_regf_addr     (o_regf_addr),
		.o_regf_rd_en    (o_regf_rd_en),
		.o_regf_wr_en    (o_regf_wr_en),
		.phase           (phase_bus.follow)
	);

endmodule

`default_nettype wire

//--- tests/ddr_phy_model.sv
`default_nettype none

module ddr_phy_model (
	input  wire                          i_sys_clk,
	input  wire                          i_sys_rst,
	input  wire                          i_tx_en,
	input  wire [3:0]                    i_tx_mode,
	input  wire                          i_rx_en,
	input  wire [3:0]                    i_rx_mode,
	input  wire                          i_frmcnt_en,
	input  wire [7:0]                    i_words,	// words before the frame counter runs out
	input  wire [7:0]                    i_early_words,	// target stops after this many, 0 = never
	input  wire                          i_nack,
	input  wire                          i_par_err,
	input  wire                          i_crc_err,
	output logic                         o_tx_mode_done,
	output logic                         o_rx_mode_done,
	output logic                         o_rx_pre,
	output logic                         o_rx_error,
	output logic                         o_frmcnt_last,
	output logic [ddr_pkg::BITCNT_W-1:0] o_bitcnt
);

	timeunit 1ns;
	timeprecision 100ps;

	integer seed;
	integer delay;
	logic [7:0] byte_cnt;	// data bytes moved in this frame
	logic acked;		// ack slot already answered
	logic in_crc;		// crc preambles have begun
	logic is_byte;
	logic is_ack;
	logic is_crc_pre;
	logic crc_phase;
	logic target_ends;

	assign crc_phase = (i_tx_en && i_tx_mode == ddr_pkg::tx_crc_value) ||
		(i_rx_en && i_rx_mode == ddr_pkg::rx_check_crc);
	assign target_ends = (i_early_words != 8'd0) && (byte_cnt >= {i_early_words[6:0], 1'b0});
	// two bytes per word
	assign o_frmcnt_last = i_frmcnt_en && (byte_cnt >= {i_words[6:0], 1'b0});

	// bit counter runs only through the crc value
	initial
	begin
		o_bitcnt = '0;
		forever
		begin
			@(posedge i_sys_clk);
			#2;
			if (!i_sys_rst || !crc_phase)
				o_bitcnt = '0;
			else
				o_bitcnt = o_bitcnt + 6'd1;
		end
	end

	// lane answers, one done per enabled phase
	initial
	begin
		seed = 32'h64dd;
		delay = 0;
		o_tx_mode_done = 1'b0;
		o_rx_mode_done = 1'b0;
		o_rx_pre = 1'b0;
		o_rx_error = 1'b0;
		byte_cnt = '0;
		acked = 1'b0;
		in_crc = 1'b0;
		forever
		begin
			@(posedge i_sys_clk);
			#2;
			if (i_tx_en && i_tx_mode == ddr_pkg::tx_special_pre)
			begin
				byte_cnt = '0;	// command preamble opens a new frame
				acked = 1'b0;
				in_crc = 1'b0;
			end
			if (i_tx_en || i_rx_en)
			begin
				if (crc_phase)
					delay = 13;	// long enough to pass the stall bits
				else
					delay = 1 + ($random(seed) & 3);
				repeat (delay)
				begin
					@(posedge i_sys_clk);
					#2;
				end
				is_byte = (i_tx_en && i_tx_mode == ddr_pkg::tx_ser_byte) ||
					(i_rx_en && i_rx_mode == ddr_pkg::rx_deser_byte);
				is_ack = i_rx_en && (i_rx_mode == ddr_pkg::rx_preamble) && !acked;
				is_crc_pre = i_tx_en && (i_tx_mode == ddr_pkg::tx_zero_pre) && acked;
				if (i_rx_en && i_rx_mode == ddr_pkg::rx_preamble)
				begin
					if (!acked)
						o_rx_pre = i_nack;	// sda left high, nobody answered
					else if (in_crc)
						o_rx_pre = 1'b1;	// good crc preamble
					else
						o_rx_pre = !target_ends;	// high = another word follows
				end
				if (i_rx_en && i_rx_mode == ddr_pkg::rx_check_parity)
					o_rx_error = i_par_err;
				if (i_rx_en && i_rx_mode == ddr_pkg::rx_check_crc)
					o_rx_error = i_crc_err;
				o_tx_mode_done = i_tx_en;
				o_rx_mode_done = i_rx_en;
				@(posedge i_sys_clk);
				#2;
				o_tx_mode_done = 1'b0;
				o_rx_mode_done = 1'b0;
				o_rx_pre = 1'b0;
				o_rx_error = 1'b0;
				if (is_byte)
					byte_cnt = byte_cnt + 8'd1;
				if (is_ack)
					acked = 1'b1;
				if (is_crc_pre)
					in_crc = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/ddr_engine_tb.sv
`default_nettype none

module ddr_engine_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic i_sys_clk;
	logic i_sys_rst;
	logic i_engine_en;
	logic i_frmcnt_last;
	logic i_tx_mode_done;
	logic i_rx_mode_done;
	logic i_rx_pre;
	logic i_rx_error;
	logic i_regf_toc;
	logic [ddr_pkg::DEV_IDX_W-1:0] i_regf_dev_index;
	logic i_regf_short_read;
	logic i_regf_wr_rd_bit;
	logic [2:0] i_regf_cmd_attr;
	logic [ddr_pkg::BITCNT_W-1:0] i_bitcnt;
	logic o_tx_en;
	ddr_pkg::tx_mode_t o_tx_mode;
	logic o_rx_en;
	ddr_pkg::rx_mode_t o_rx_mode;
	logic o_frmcnt_en;
	logic o_bitcnt_en;
	logic o_bitcnt_rst;
	logic o_regf_wr_en;
	logic o_regf_rd_en;
	ddr_pkg::regf_addr_t o_regf_addr;
	logic o_sclstall_en;
	logic [ddr_pkg::STALL_W-1:0] o_sclstall_no_of_cycles;
	logic o_engine_done;
	logic [ddr_pkg::SPECIAL_W-1:0] o_tx_special_data;
	ddr_pkg::err_t o_regf_error_type;

	// target behaviour for the running frame
	logic [7:0] words;
	logic [7:0] early_words;
	logic nack;
	logic par_err;
	logic crc_err;
	logic [ddr_pkg::SPECIAL_W-1:0] exp_special;

	int errors;
	int timeouts;
	int frames;
	int done_pulses;
	logic saw_rx_error;
	logic saw_check_crc;
	ddr_pkg::tx_mode_t tx_seen[$];	// tx mode of every finished tx phase
	ddr_pkg::regf_addr_t addr_seen[$];	// pointer at every data byte done
	ddr_pkg::tx_mode_t exp_tx[$];

	logic crc_phase;
	logic exp_crc_stall;
	logic close_phase;
	logic [ddr_pkg::STALL_W-1:0] exp_stall_len;
	logic cmd_tx;
	logic frm_on;

	ddr_engine ddr_engine_i (.*);

	ddr_phy_model phy_i (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_tx_en        (o_tx_en),
		.i_tx_mode      (o_tx_mode),
		.i_rx_en        (o_rx_en),
		.i_rx_mode      (o_rx_mode),
		.i_frmcnt_en    (o_frmcnt_en),
		.i_words        (words),
		.i_early_words  (early_words),
		.i_nack         (nack),
		.i_par_err      (par_err),
		.i_crc_err      (crc_err),
		.o_tx_mode_done (i_tx_mode_done),
		.o_rx_mode_done (i_rx_mode_done),
		.o_rx_pre       (i_rx_pre),
		.o_rx_error     (i_rx_error),
		.o_frmcnt_last  (i_frmcnt_last),
		.o_bitcnt       (i_bitcnt)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #10 i_sys_clk = ~i_sys_clk;
	end

	assign crc_phase = (o_tx_en && o_tx_mode == ddr_pkg::tx_crc_value) ||
		(o_rx_en && o_rx_mode == ddr_pkg::rx_check_crc);
	assign exp_crc_stall = (i_bitcnt == 6'd11) || (i_bitcnt == 6'd12);	// scl held on these bits
	assign close_phase = o_tx_en &&
		(o_tx_mode == ddr_pkg::tx_restart_pat || o_tx_mode == ddr_pkg::tx_exit_pat);
	assign exp_stall_len = i_regf_toc ? 5'd16 : 5'd10;
	assign cmd_tx = o_tx_en && (o_tx_mode == ddr_pkg::tx_special_pre ||
		o_tx_mode == ddr_pkg::tx_seven_zeros || o_tx_mode == ddr_pkg::tx_ser_address);
	// word counter runs for the data words and everything after the command
	assign frm_on = (o_tx_en && o_tx_mode == ddr_pkg::tx_ser_byte) ||
		(o_rx_en && (o_rx_mode == ddr_pkg::rx_deser_byte || o_rx_mode == ddr_pkg::rx_error)) ||
		close_phase;

	// address byte = device index + 8
	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == ddr_pkg::tx_ser_address) |-> (o_tx_special_data == exp_special))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_tx_special_data exp %h got %h", exp_special,
			$sampled(o_tx_special_data));
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		crc_phase |-> (o_sclstall_en == exp_crc_stall))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_sclstall_en exp %h got %h at bit %h", $sampled(exp_crc_stall),
			$sampled(o_sclstall_en), $sampled(i_bitcnt));
	end

	// stall held until the pattern is out
	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		close_phase |-> (o_sclstall_no_of_cycles == exp_stall_len) &&
		(o_sclstall_en == !i_tx_mode_done))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_sclstall_no_of_cycles exp %h got %h, o_sclstall_en %h",
			$sampled(exp_stall_len), $sampled(o_sclstall_no_of_cycles), $sampled(o_sclstall_en));
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_rx_en && o_rx_mode == ddr_pkg::rx_error) |-> o_bitcnt_rst)
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_bitcnt_rst exp %h got %h", 1'b1, $sampled(o_bitcnt_rst));
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(cmd_tx || frm_on) |-> (o_frmcnt_en == frm_on))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_frmcnt_en exp %h got %h", $sampled(frm_on), $sampled(o_frmcnt_en));
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en || o_rx_en) |-> o_bitcnt_en)
	else
	begin
		errors = errors + 1;
		$display("[ERROR] o_bitcnt_en exp %h got %h", 1'b1, $sampled(o_bitcnt_en));
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_engine_done |=> !o_engine_done)
	else
	begin
		errors = errors + 1;
		$display("engine done stayed high for more than one cycle");
	end

	// sampled mid-cycle, everything settled
	always @(negedge i_sys_clk)
	begin
		if (o_tx_en && i_tx_mode_done)
			tx_seen.push_back(o_tx_mode);
		if ((o_regf_rd_en && i_tx_mode_done) || (o_regf_wr_en && i_rx_mode_done))
			addr_seen.push_back(o_regf_addr);
		if (o_rx_en && o_rx_mode == ddr_pkg::rx_error)
			saw_rx_error = 1'b1;
		if (o_rx_en && o_rx_mode == ddr_pkg::rx_check_crc)
			saw_check_crc = 1'b1;
		if (o_engine_done)
			done_pulses = done_pulses + 1;
	end

	task automatic next_cycle();
		@(posedge i_sys_clk);
		#2;
	endtask

	task automatic run_frame(input logic rd, input logic toc, input logic [4:0] idx,
		input logic [2:0] attr, input int n_words, input int n_early, input logic short_rd,
		input logic nck, input logic perr, input logic cerr);
		int n;
		i_regf_wr_rd_bit = rd;
		i_regf_toc = toc;
		i_regf_dev_index = idx;
		i_regf_cmd_attr = attr;
		i_regf_short_read = short_rd;
		words = 8'(n_words);
		early_words = 8'(n_early);
		nack = nck;
		par_err = perr;
		crc_err = cerr;
		exp_special = 8'(idx) + 8'd8;
		tx_seen.delete();
		addr_seen.delete();
		saw_rx_error = 1'b0;
		saw_check_crc = 1'b0;
		done_pulses = 0;
		i_engine_en = 1'b1;	// accepted in idle
		next_cycle();
		i_engine_en = 1'b0;
		n = 0;
		while (!o_engine_done && n < 4000)
		begin
			next_cycle();
			n = n + 1;
		end
		if (!o_engine_done)
		begin
			timeouts = timeouts + 1;
			$display("timeout: frame %0d never raised o_engine_done", frames);
		end
		repeat (3) next_cycle();	// room for a stray second pulse
		frames = frames + 1;
	endtask

	task automatic expect_error_type(input ddr_pkg::err_t exp);
		assert (o_regf_error_type == exp)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_regf_error_type exp %h got %h", exp, o_regf_error_type);
		end
		assert (done_pulses == 1)
		else
		begin
			errors = errors + 1;
			$display("o_engine_done pulsed %0d times in frame %0d", done_pulses, frames - 1);
		end
	endtask

	task automatic verify_addr_run(input int base, input int n_bytes);
		int i;
		assert (addr_seen.size() == n_bytes)
		else
		begin
			errors = errors + 1;
			$display("%0d data bytes were addressed, expected %0d", addr_seen.size(), n_bytes);
		end
		for (i = 0; i < addr_seen.size() && i < n_bytes; i++)
			assert (addr_seen[i] == 12'(base + i))
			else
			begin
				errors = errors + 1;
				$display("[ERROR] o_regf_addr exp %h got %h", 12'(base + i), addr_seen[i]);
			end
	endtask

	// order of tx phases in a write frame
	task automatic expected_write_modes(input int n_words, input logic toc);
		int w;
		exp_tx.delete();
		exp_tx.push_back(ddr_pkg::tx_special_pre);
		exp_tx.push_back(ddr_pkg::tx_zero_pre);	// write bit
		exp_tx.push_back(ddr_pkg::tx_seven_zeros);
		exp_tx.push_back(ddr_pkg::tx_ser_address);
		exp_tx.push_back(ddr_pkg::tx_calc_parity);
		exp_tx.push_back(ddr_pkg::tx_one_pre);	// ack preamble
		for (w = 0; w < n_words; w++)
		begin
			exp_tx.push_back(ddr_pkg::tx_ser_byte);
			exp_tx.push_back(ddr_pkg::tx_ser_byte);
			exp_tx.push_back(ddr_pkg::tx_calc_parity);
			if (w < n_words - 1)
				exp_tx.push_back(ddr_pkg::tx_one_pre);
		end
		exp_tx.push_back(ddr_pkg::tx_zero_pre);
		exp_tx.push_back(ddr_pkg::tx_one_pre);
		exp_tx.push_back(ddr_pkg::tx_token_crc);
		exp_tx.push_back(ddr_pkg::tx_crc_value);
		if (toc)
			exp_tx.push_back(ddr_pkg::tx_exit_pat);
		else
			exp_tx.push_back(ddr_pkg::tx_restart_pat);
	endtask

	task automatic compare_tx_order();
		int i;
		assert (tx_seen.size() == exp_tx.size())
		else
		begin
			errors = errors + 1;
			$display("tx lane ran %0d phases, expected %0d", tx_seen.size(), exp_tx.size());
		end
		for (i = 0; i < exp_tx.size() && i < tx_seen.size(); i++)
			assert (tx_seen[i] == exp_tx[i])
			else
			begin
				errors = errors + 1;
				$display("[ERROR] o_tx_mode phase %0d exp %h got %h", i, exp_tx[i], tx_seen[i]);
			end
	endtask

	task automatic closing_pattern_is(input ddr_pkg::tx_mode_t mode);
		assert (tx_seen.size() > 0 && tx_seen[tx_seen.size() - 1] == mode)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] o_tx_mode closing exp %h got %h", mode,
				(tx_seen.size() > 0) ? tx_seen[tx_seen.size() - 1] : ddr_pkg::tx_seven_zeros);
		end
	endtask

	task automatic require_seen(input logic flag, input string what);
		assert (flag)
		else
		begin
			errors = errors + 1;
			$display("frame %0d never reached %s", frames - 1, what);
		end
	endtask

	initial
	begin
		i_sys_rst = 1'b0;
		i_engine_en = 1'b0;
		i_regf_toc = 1'b0;
		i_regf_dev_index = '0;
		i_regf_short_read = 1'b0;
		i_regf_wr_rd_bit = 1'b0;
		i_regf_cmd_attr = 3'b000;
		words = 8'd1;
		early_words = 8'd0;
		nack = 1'b0;
		par_err = 1'b0;
		crc_err = 1'b0;
		exp_special = 8'd8;
		errors = 0;
		timeouts = 0;
		frames = 0;
		done_pulses = 0;
		saw_rx_error = 1'b0;
		saw_check_crc = 1'b0;
		repeat (4) @(posedge i_sys_clk);
		#2;
		i_sys_rst = 1'b1;
		assert (!o_tx_en && !o_rx_en && !o_frmcnt_en && !o_bitcnt_en && !o_regf_rd_en &&
			!o_regf_wr_en && !o_sclstall_en && !o_engine_done &&
			o_regf_error_type == ddr_pkg::err_success)
		else
		begin
			errors = errors + 1;
			$display("outputs were not quiet after reset");
		end

		// regular write, three words, exit
		run_frame(1'b0, 1'b1, 5'd5, 3'b000, 3, 0, 1'b0, 1'b0, 1'b0, 1'b0);
		expected_write_modes(3, 1'b1);
		compare_tx_order();
		expect_error_type(ddr_pkg::err_success);
		verify_addr_run(1, 6);

		// immediate write starts higher up
		run_frame(1'b0, 1'b0, 5'd17, 3'b001, 2, 0, 1'b0, 1'b0, 1'b0, 1'b0);
		expect_error_type(ddr_pkg::err_success);
		verify_addr_run(20, 4);
		closing_pattern_is(ddr_pkg::tx_restart_pat);

		// plain read
		run_frame(1'b1, 1'b0, 5'd2, 3'b000, 2, 0, 1'b0, 1'b0, 1'b0, 1'b0);
		expect_error_type(ddr_pkg::err_success);
		verify_addr_run(10, 4);
		require_seen(saw_check_crc, "the crc check");

		// no target answers
		run_frame(1'b0, 1'b0, 5'd9, 3'b000, 2, 0, 1'b0, 1'b1, 1'b0, 1'b0);
		expect_error_type(ddr_pkg::err_nack);
		require_seen(saw_rx_error, "the error state");
		verify_addr_run(1, 0);
		closing_pattern_is(ddr_pkg::tx_restart_pat);

		// bad parity on the first read word
		run_frame(1'b1, 1'b1, 5'd3, 3'b000, 2, 0, 1'b0, 1'b0, 1'b1, 1'b0);
		expect_error_type(ddr_pkg::err_parity);
		require_seen(saw_rx_error, "the error state");
		closing_pattern_is(ddr_pkg::tx_exit_pat);

		// target stops after one word, short read flagged
		run_frame(1'b1, 1'b0, 5'd4, 3'b000, 4, 1, 1'b1, 1'b0, 1'b0, 1'b0);
		expect_error_type(ddr_pkg::err_short_read);
		verify_addr_run(10, 2);

		// same early end, allowed
		run_frame(1'b1, 1'b1, 5'd4, 3'b000, 4, 1, 1'b0, 1'b0, 1'b0, 1'b0);
		expect_error_type(ddr_pkg::err_success);
		require_seen(saw_check_crc, "the crc check");
		closing_pattern_is(ddr_pkg::tx_exit_pat);

		// corrupted crc from the target
		run_frame(1'b1, 1'b0, 5'd31, 3'b000, 1, 0, 1'b0, 1'b0, 1'b0, 1'b1);
		expect_error_type(ddr_pkg::err_crc);
		closing_pattern_is(ddr_pkg::tx_restart_pat);

		$display("frames: %0d, errors: %0d, timeouts: %0d", frames, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
logic/ddr_pkg.sv
logic/ddr_phase_if.sv
logic/ddr_frame_fsm.sv
logic/ddr_lane_ctrl.sv
logic/ddr_regf_addr.sv
logic/ddr_engine.sv
tests/ddr_phy_model.sv
tests/ddr_engine_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module ddr_engine_tb -Mdir obj_dir -f project.f
	./obj_dir/Vddr_engine_tb | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@grep -q "All tests passed!" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log
